/* src/dmem_pkg.sv */
////////////////////////////////////////
// shared widths and types of the data memory path
// access size, bus protection and privilege codes
////////////////////////////////////////

`default_nettype none

package dmem_pkg;

  // data path fixed at one 32 bit word
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0]   data_t;
  typedef logic [XLEN-1:0]   addr_t;
  // one enable per byte lane
  typedef logic [XLEN/8-1:0] be_t;

  ////////////////////////////////////////
  // access size
  ////////////////////////////////////////
  typedef logic [2:0] size_t;

  localparam size_t SIZE_BYTE  = 3'b000;
  localparam size_t SIZE_HWORD = 3'b001;
  localparam size_t SIZE_WORD  = 3'b010;
  // wider than the bus, always rejected as misaligned
  localparam size_t SIZE_DWORD = 3'b011;

  ////////////////////////////////////////
  // bus protection, one flag per bit
  ////////////////////////////////////////
  typedef logic [2:0] prot_t;

  localparam prot_t PROT_DATA = 3'b001;
  localparam prot_t PROT_USER = 3'b010;
  localparam prot_t PROT_PRIV = 3'b100;

  // privilege level of the hart
  typedef logic [1:0] prv_t;

  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_S = 2'b01;
  // 2'b10 reserved
  localparam prv_t PRV_M = 2'b11;

endpackage

`default_nettype wire

/* src/dmem_lane_fmt.sv */
////////////////////////////////////////
// byte lane formatter between CPU and core stage
// store data replication, load data extraction
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem_lane_fmt (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // request from the CPU
  input  wire                  mem_req_i,
  input  wire dmem_pkg::addr_t mem_adr_i,
  input  wire dmem_pkg::size_t mem_size_i,
  input  wire                  mem_we_i,
  input  wire dmem_pkg::data_t mem_d_i,
  // response from the core stage
  input  wire dmem_pkg::data_t rsp_q_i,
  input  wire dmem_pkg::addr_t rsp_adr_i,
  input  wire dmem_pkg::size_t rsp_size_i,
  input  wire                  rsp_ack_i,
  input  wire                  rsp_err_i,
  // request toward the core stage
  output logic                 req_o,
  output dmem_pkg::addr_t      adr_o,
  output dmem_pkg::size_t      size_o,
  output logic                 we_o,
  output dmem_pkg::data_t      d_o,
  // response toward the CPU
  output dmem_pkg::data_t      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o
);

  import dmem_pkg::*;

  // right shift that brings the addressed lane down to bit 0
  logic [4:0] lane_sh;
  data_t      rsp_shifted;

  // request control passes straight on
  assign req_o  = mem_req_i;
  assign adr_o  = mem_adr_i;
  assign size_o = mem_size_i;
  assign we_o   = mem_we_i;

  // replicate low byte / halfword so every enabled lane sees the data
  always_comb
  begin
    case (mem_size_i)
      SIZE_BYTE:  d_o = {4{mem_d_i[7:0]}};
      SIZE_HWORD: d_o = {2{mem_d_i[15:0]}};
      default:    d_o = mem_d_i;
    endcase
  end

  ////////////////////////////////////////
  // load path
  ////////////////////////////////////////
  assign lane_sh     = {rsp_adr_i[1:0], 3'b000};
  assign rsp_shifted = rsp_q_i >> lane_sh;

  // zero extended, sign handled by the CPU
  always_comb
  begin
    case (rsp_size_i)
      SIZE_BYTE:  mem_q_o = data_t'(rsp_shifted[7:0]);
      SIZE_HWORD: mem_q_o = data_t'(rsp_shifted[15:0]);
      default:    mem_q_o = rsp_shifted;
    endcase
  end

  assign mem_ack_o = rsp_ack_i;
  assign mem_err_o = rsp_err_i;

  // a response is either good or failed, never both
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rsp_ack_i && rsp_err_i))
    else $error("lane_fmt: ack and err together");

endmodule

`default_nettype wire

/* src/dmem_nodcache_core.sv */
////////////////////////////////////////
// no data cache core stage
// alignment check, request hold register
// in-flight and discard counters, response gating
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem_nodcache_core #(
  parameter int unsigned DEPTH = 2
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // CPU side, store data already lane placed
  input  wire                  mem_req_i,
  input  wire dmem_pkg::addr_t mem_adr_i,
  input  wire dmem_pkg::size_t mem_size_i,
  input  wire                  mem_we_i,
  input  wire dmem_pkg::data_t mem_d_i,
  input  wire dmem_pkg::prv_t  st_prv_i,
  output logic                 mem_misaligned_o,
  output dmem_pkg::data_t      mem_q_o,
  output dmem_pkg::addr_t      mem_adr_o,
  output dmem_pkg::size_t      mem_size_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  // BIU side
  output logic                 biu_stb_o,
  output dmem_pkg::addr_t      biu_adri_o,
  output dmem_pkg::size_t      biu_size_o,
  output logic                 biu_we_o,
  output dmem_pkg::prot_t      biu_prot_o,
  output dmem_pkg::data_t      biu_d_o,
  input  wire                  biu_stb_ack_i,
  input  wire dmem_pkg::data_t biu_q_i,
  input  wire dmem_pkg::addr_t biu_adro_i,
  input  wire dmem_pkg::size_t biu_sizeo_i,
  input  wire                  biu_ack_i,
  input  wire                  biu_err_i
);

  import dmem_pkg::*;

  // wide enough to hold DEPTH itself
  localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

  logic             misaligned;
  logic             rsp;
  logic             deliver;

  // held request, payload only
  logic             hold_req;
  addr_t            hold_adr;
  size_t            hold_size;
  logic             hold_we;
  data_t            hold_d;

  logic [CNT_W-1:0] inflight;
  logic [CNT_W-1:0] discard;

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////
  always_comb
  begin
    case (mem_size_i)
      SIZE_BYTE:  misaligned = 1'b0;
      SIZE_HWORD: misaligned = mem_adr_i[0];
      SIZE_WORD:  misaligned = |mem_adr_i[1:0];
      // doubleword does not fit the 32 bit bus
      SIZE_DWORD: misaligned = 1'b1;
      default:    misaligned = 1'b1;
    endcase
    // only a presented request can be misaligned
    misaligned = misaligned & mem_req_i;
  end

  // one cycle pulse after the bad request
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      mem_misaligned_o <= 1'b0;
    else
      mem_misaligned_o <= misaligned;
  end

  ////////////////////////////////////////
  // request hold
  ////////////////////////////////////////
  // capture a fresh request, a waiting one stays stable
  always_ff @(posedge clk_i)
  begin
    if (mem_req_i && !hold_req)
    begin
      hold_adr  <= mem_adr_i;
      hold_size <= mem_size_i;
      hold_we   <= mem_we_i;
      hold_d    <= mem_d_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      hold_req <= 1'b0;
    else if (misaligned || mem_err_o)
      hold_req <= 1'b0;
    else
      hold_req <= (mem_req_i | hold_req) & ~biu_stb_ack_i;
  end

  assign biu_stb_o  = (mem_req_i | hold_req) & ~misaligned;
  assign biu_adri_o = hold_req ? hold_adr  : mem_adr_i;
  assign biu_size_o = hold_req ? hold_size : mem_size_i;
  assign biu_we_o   = hold_req ? hold_we   : mem_we_i;
  assign biu_d_o    = hold_req ? hold_d    : mem_d_i;

  // user or privileged data access
  assign biu_prot_o = PROT_DATA | ((st_prv_i == PRV_U) ? PROT_USER : PROT_PRIV);

  ////////////////////////////////////////
  // transfer counters
  ////////////////////////////////////////
  assign rsp = biu_ack_i | biu_err_i;

  // accepted minus completed
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      inflight <= '0;
    else
    begin
      case ({biu_stb_ack_i, rsp})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // responses still owed to the aborted stream
  // the one completing this cycle is already accounted for
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      discard <= '0;
    else if (misaligned || mem_err_o)
    begin
      if (|inflight && rsp)
        discard <= inflight - 1'b1;
      else
        discard <= inflight;
    end
    else if (|discard && rsp)
      discard <= discard - 1'b1;
  end

  ////////////////////////////////////////
  // response to the CPU
  ////////////////////////////////////////
  assign deliver    = ~|discard & ~misaligned;
  assign mem_ack_o  = biu_ack_i & deliver;
  assign mem_err_o  = biu_err_i & deliver;
  assign mem_q_o    = biu_q_i;
  assign mem_adr_o  = biu_adro_i;
  assign mem_size_o = biu_sizeo_i;

  a_inflight_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    inflight <= CNT_W'(DEPTH))
    else $error("core: more than DEPTH transfers in flight");

  // a completion needs a transfer on the bus
  a_inflight_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(inflight == '0 && rsp && !biu_stb_ack_i))
    else $error("core: response with nothing in flight");

endmodule

`default_nettype wire

/* src/dmem_biu.sv */
////////////////////////////////////////
// bus interface unit to the external word bus
// outstanding transfer queue, byte enables
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem_biu #(
  parameter int unsigned DEPTH = 2
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // core stage side
  input  wire                  biu_stb_i,
  input  wire dmem_pkg::addr_t biu_adri_i,
  input  wire dmem_pkg::size_t biu_size_i,
  input  wire                  biu_we_i,
  input  wire dmem_pkg::prot_t biu_prot_i,
  input  wire dmem_pkg::data_t biu_d_i,
  output logic                 biu_stb_ack_o,
  output dmem_pkg::data_t      biu_q_o,
  output dmem_pkg::addr_t      biu_adro_o,
  output dmem_pkg::size_t      biu_sizeo_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o,
  // external bus
  output logic                 bus_req_o,
  output dmem_pkg::addr_t      bus_adr_o,
  output logic                 bus_we_o,
  output dmem_pkg::be_t        bus_be_o,
  output dmem_pkg::prot_t      bus_prot_o,
  output dmem_pkg::data_t      bus_d_o,
  input  wire                  bus_gnt_i,
  input  wire                  bus_rvalid_i,
  input  wire dmem_pkg::data_t bus_rdata_i,
  input  wire                  bus_err_i
);

  import dmem_pkg::*;

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // address and size of each granted transfer, oldest at rd_ptr
  addr_t            q_adr  [DEPTH];
  size_t            q_size [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////
  assign full      = (count == CNT_W'(DEPTH));
  assign bus_req_o = biu_stb_i & ~full;
  // accepted in the grant cycle
  assign push          = bus_req_o & bus_gnt_i;
  assign biu_stb_ack_o = push;

  // word address, lanes chosen by the enables
  assign bus_adr_o  = {biu_adri_i[XLEN-1:2], 2'b00};
  assign bus_we_o   = biu_we_i;
  assign bus_prot_o = biu_prot_i;
  assign bus_d_o    = biu_d_i;

  always_comb
  begin
    case (biu_size_i)
      SIZE_BYTE:  bus_be_o = be_t'(4'b0001 << biu_adri_i[1:0]);
      SIZE_HWORD: bus_be_o = be_t'(4'b0011 << {biu_adri_i[1], 1'b0});
      SIZE_WORD:  bus_be_o = 4'b1111;
      default:    bus_be_o = 4'b0000;
    endcase
  end

  ////////////////////////////////////////
  // outstanding queue
  ////////////////////////////////////////
  assign pop = bus_rvalid_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      q_adr[wr_ptr]  <= biu_adri_i;
      q_size[wr_ptr] <= biu_size_i;
    end
  end

  // pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // response phase, in order
  ////////////////////////////////////////
  assign biu_q_o     = bus_rdata_i;
  assign biu_adro_o  = q_adr[rd_ptr];
  assign biu_sizeo_o = q_size[rd_ptr];
  assign biu_ack_o   = bus_rvalid_i & ~bus_err_i;
  assign biu_err_o   = bus_rvalid_i & bus_err_i;

  // every response must belong to an earlier grant
  a_rsp_queued: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_i |-> count != '0)
    else $error("biu: response with empty queue");

endmodule

`default_nettype wire

/* src/dmem_top.sv */
////////////////////////////////////////
// data memory path without data cache
// lane formatter, core stage and BIU
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem_top #(
  parameter int unsigned DEPTH = 2
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // CPU side
  input  wire                  mem_req_i,
  input  wire dmem_pkg::addr_t mem_adr_i,
  input  wire dmem_pkg::size_t mem_size_i,
  input  wire                  mem_we_i,
  input  wire dmem_pkg::data_t mem_d_i,
  input  wire dmem_pkg::prv_t  st_prv_i,
  output dmem_pkg::data_t      mem_q_o,
  output logic                 mem_ack_o,
  output logic                 mem_err_o,
  output logic                 mem_misaligned_o,
  // external bus
  output logic                 bus_req_o,
  output dmem_pkg::addr_t      bus_adr_o,
  output logic                 bus_we_o,
  output dmem_pkg::be_t        bus_be_o,
  output dmem_pkg::prot_t      bus_prot_o,
  output dmem_pkg::data_t      bus_d_o,
  input  wire                  bus_gnt_i,
  input  wire                  bus_rvalid_i,
  input  wire dmem_pkg::data_t bus_rdata_i,
  input  wire                  bus_err_i
);

  import dmem_pkg::*;

  // formatter to core stage
  logic  fmt_req;
  addr_t fmt_adr;
  size_t fmt_size;
  logic  fmt_we;
  data_t fmt_d;

  // core stage back to formatter
  data_t rsp_q;
  addr_t rsp_adr;
  size_t rsp_size;
  logic  rsp_ack;
  logic  rsp_err;

  // core stage to BIU
  logic  biu_stb;
  addr_t biu_adri;
  size_t biu_size;
  logic  biu_we;
  prot_t biu_prot;
  data_t biu_d;

  // BIU back to core stage
  logic  biu_stb_ack;
  data_t biu_q;
  addr_t biu_adro;
  size_t biu_sizeo;
  logic  biu_ack;
  logic  biu_err;

  dmem_lane_fmt u_lane_fmt (
    .clk_i     (clk_i),      .rst_ni    (rst_ni),
    .mem_req_i (mem_req_i),  .mem_adr_i (mem_adr_i),  .mem_size_i (mem_size_i),
    .mem_we_i  (mem_we_i),   .mem_d_i   (mem_d_i),
    .rsp_q_i   (rsp_q),      .rsp_adr_i (rsp_adr),    .rsp_size_i (rsp_size),
    .rsp_ack_i (rsp_ack),    .rsp_err_i (rsp_err),
    .req_o     (fmt_req),    .adr_o     (fmt_adr),    .size_o     (fmt_size),
    .we_o      (fmt_we),     .d_o       (fmt_d),
    .mem_q_o   (mem_q_o),    .mem_ack_o (mem_ack_o),  .mem_err_o  (mem_err_o)
  );

  dmem_nodcache_core #(
    .DEPTH (DEPTH)
  ) u_core (
    .clk_i            (clk_i),            .rst_ni        (rst_ni),
    .mem_req_i        (fmt_req),          .mem_adr_i     (fmt_adr),
    .mem_size_i       (fmt_size),         .mem_we_i      (fmt_we),
    .mem_d_i          (fmt_d),            .st_prv_i      (st_prv_i),
    .mem_misaligned_o (mem_misaligned_o), .mem_q_o       (rsp_q),
    .mem_adr_o        (rsp_adr),          .mem_size_o    (rsp_size),
    .mem_ack_o        (rsp_ack),          .mem_err_o     (rsp_err),
    .biu_stb_o        (biu_stb),          .biu_adri_o    (biu_adri),
    .biu_size_o       (biu_size),         .biu_we_o      (biu_we),
    .biu_prot_o       (biu_prot),         .biu_d_o       (biu_d),
    .biu_stb_ack_i    (biu_stb_ack),      .biu_q_i       (biu_q),
    .biu_adro_i       (biu_adro),         .biu_sizeo_i   (biu_sizeo),
    .biu_ack_i        (biu_ack),          .biu_err_i     (biu_err)
  );

  dmem_biu #(
    .DEPTH (DEPTH)
  ) u_biu (
    .clk_i         (clk_i),        .rst_ni       (rst_ni),
    .biu_stb_i     (biu_stb),      .biu_adri_i   (biu_adri),
    .biu_size_i    (biu_size),     .biu_we_i     (biu_we),
    .biu_prot_i    (biu_prot),     .biu_d_i      (biu_d),
    .biu_stb_ack_o (biu_stb_ack),  .biu_q_o      (biu_q),
    .biu_adro_o    (biu_adro),     .biu_sizeo_o  (biu_sizeo),
    .biu_ack_o     (biu_ack),      .biu_err_o    (biu_err),
    .bus_req_o     (bus_req_o),    .bus_adr_o    (bus_adr_o),
    .bus_we_o      (bus_we_o),     .bus_be_o     (bus_be_o),
    .bus_prot_o    (bus_prot_o),   .bus_d_o      (bus_d_o),
    .bus_gnt_i     (bus_gnt_i),    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),  .bus_err_i    (bus_err_i)
  );

endmodule

`default_nettype wire

/* dv/tb_bus_responder.sv */
////////////////////////////////////////
// external word bus slave model
// 64 word memory, random grant stalls and latencies
// error window at words 56 to 59
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_bus_responder #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  wire         bus_req_i,
  input  wire  [31:0] bus_adr_i,
  input  wire         bus_we_i,
  input  wire  [3:0]  bus_be_i,
  input  wire  [31:0] bus_d_i,
  output logic        bus_gnt_o,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o,
  output logic        bus_err_o
);

  logic [31:0] mem [64];
  logic [31:0] rnd_lat;
  logic [31:0] rnd_gnt;
  logic [31:0] cyc;
  logic [31:0] last_due;
  // in order response queue
  logic [31:0] rsp_data [8];
  logic        rsp_err  [8];
  logic [31:0] rsp_due  [8];
  logic [2:0]  wr_ptr;
  logic [2:0]  rd_ptr;
  wire  [5:0]  widx   = bus_adr_i[7:2];
  wire         in_err = (bus_adr_i[7:4] == 4'he);

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    rnd_lat = SEED;
    rnd_gnt = SEED ^ 32'h5555_aaaa;
    for (int i = 0; i < 64; i++)
      mem[i] <= 32'h9e37_79b9 * (i + 1);
  end

  // address phase, response due 1 to 3 cycles later and never before the previous one
  always @(posedge clk_i or negedge rst_ni)
  begin : grant_side
    logic [31:0] due;
    if (!rst_ni)
    begin
      cyc      <= '0;
      wr_ptr   <= '0;
      last_due <= '0;
    end
    else
    begin
      cyc <= cyc + 1;
      if (bus_req_i && bus_gnt_o)
      begin
        rnd_lat = next_rand(rnd_lat);
        due = cyc + 32'd1 + (rnd_lat[31:24] % 3);
        if (due <= last_due)
          due = last_due + 1;
        last_due         <= due;
        rsp_due[wr_ptr]  <= due;
        rsp_err[wr_ptr]  <= in_err;
        rsp_data[wr_ptr] <= in_err ? 32'h0 : mem[widx];
        wr_ptr           <= wr_ptr + 1'b1;
        // failed stores leave memory alone
        if (bus_we_i && !in_err)
          for (int b = 0; b < 4; b++)
            if (bus_be_i[b])
              mem[widx][8*b +: 8] <= bus_d_i[8*b +: 8];
      end
    end
  end

  // grant and response driven on the falling edge
  always @(negedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bus_gnt_o    <= 1'b0;
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
      bus_err_o    <= 1'b0;
      rd_ptr       <= '0;
    end
    else
    begin
      rnd_gnt = next_rand(rnd_gnt);
      // stall about one cycle in four
      bus_gnt_o <= (rnd_gnt[31:30] != 2'b00);
      if (wr_ptr != rd_ptr && rsp_due[rd_ptr] <= cyc)
      begin
        bus_rvalid_o <= 1'b1;
        bus_rdata_o  <= rsp_data[rd_ptr];
        bus_err_o    <= rsp_err[rd_ptr];
        rd_ptr       <= rd_ptr + 1'b1;
      end
      else
      begin
        bus_rvalid_o <= 1'b0;
        bus_err_o    <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_dmem_top.sv */
////////////////////////////////////////
// testbench of the data memory path
// stimulus, reference model, checking assertions
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dmem_top;

  import dmem_pkg::*;

  localparam int NREQ = 160;

  logic clk, rst_n;
  logic mem_req, mem_we;
  addr_t mem_adr;
  size_t mem_size;
  data_t mem_d;
  prv_t st_prv;
  wire data_t mem_q;
  wire mem_ack, mem_err, mem_misaligned;
  wire bus_req, bus_we, bus_gnt, bus_rvalid, bus_err;
  wire addr_t bus_adr;
  wire be_t bus_be;
  wire prot_t bus_prot;
  wire data_t bus_d, bus_rdata;
  logic [31:0] rnd;

  // reference model state
  data_t ref_mem [64];
  data_t q_exp [8];
  logic q_load [8];
  logic q_disc [8];
  logic [2:0] q_wr, q_rd;
  logic pending, mis_d;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic is_mis(input addr_t a, input size_t s);
    case (s)
      SIZE_BYTE:  return 1'b0;
      SIZE_HWORD: return a[0];
      SIZE_WORD:  return |a[1:0];
      default:    return 1'b1;
    endcase
  endfunction

  function automatic be_t exp_be(input addr_t a, input size_t s);
    case (s)
      SIZE_BYTE:  return be_t'(4'b0001 << a[1:0]);
      SIZE_HWORD: return be_t'(4'b0011 << a[1:0]);
      default:    return 4'b1111;
    endcase
  endfunction

  // zero extended lanes of a memory word
  function automatic data_t load_value(input data_t w, input addr_t a, input size_t s);
    case (s)
      SIZE_BYTE:  return {24'h0, w[{a[1:0], 3'b000} +: 8]};
      SIZE_HWORD: return {16'h0, w[{a[1], 4'b0000} +: 16]};
      default:    return w;
    endcase
  endfunction

  function automatic data_t store_merge(input data_t w, input addr_t a, input size_t s,
                                        input data_t d);
    data_t r;
    r = w;
    case (s)
      SIZE_BYTE:  r[{a[1:0], 3'b000} +: 8] = d[7:0];
      SIZE_HWORD: r[{a[1:0], 3'b000} +: 16] = d[15:0];
      default:    r = d;
    endcase
    return r;
  endfunction

  task automatic report_fail(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  dmem_top #(.DEPTH(2)) dut0 (
    .clk_i(clk), .rst_ni(rst_n), .mem_req_i(mem_req), .mem_adr_i(mem_adr),
    .mem_size_i(mem_size), .mem_we_i(mem_we), .mem_d_i(mem_d), .st_prv_i(st_prv),
    .mem_q_o(mem_q), .mem_ack_o(mem_ack), .mem_err_o(mem_err),
    .mem_misaligned_o(mem_misaligned), .bus_req_o(bus_req), .bus_adr_o(bus_adr),
    .bus_we_o(bus_we), .bus_be_o(bus_be), .bus_prot_o(bus_prot), .bus_d_o(bus_d),
    .bus_gnt_i(bus_gnt), .bus_rvalid_i(bus_rvalid), .bus_rdata_i(bus_rdata),
    .bus_err_i(bus_err)
  );

  tb_bus_responder #(.SEED(32'hcfcc_cfab)) u_responder (
    .clk_i(clk), .rst_ni(rst_n), .bus_req_i(bus_req), .bus_adr_i(bus_adr),
    .bus_we_i(bus_we), .bus_be_i(bus_be), .bus_d_i(bus_d), .bus_gnt_o(bus_gnt),
    .bus_rvalid_o(bus_rvalid), .bus_rdata_o(bus_rdata), .bus_err_o(bus_err)
  );

  wire       grant        = bus_req && bus_gnt;
  wire       mis_now      = mem_req && is_mis(mem_adr, mem_size);
  wire [2:0] outst        = q_wr - q_rd;
  wire       head_deliver = !q_disc[q_rd] && !mis_now;
  wire       err_seen     = bus_rvalid && bus_err && head_deliver;

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  initial
    for (int i = 0; i < 64; i++)
      ref_mem[i] <= 32'h9e37_79b9 * (i + 1);

  always @(posedge clk)
    if (grant && mem_we && mem_adr[7:4] != 4'he)
      ref_mem[mem_adr[7:2]] <= store_merge(ref_mem[mem_adr[7:2]], mem_adr, mem_size, mem_d);

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      q_wr    <= '0;
      q_rd    <= '0;
      pending <= 1'b0;
      mis_d   <= 1'b0;
    end
    else
    begin
      mis_d   <= mis_now;
      pending <= ((mem_req && !mis_now) || pending) && !grant && !(mis_now || err_seen);
      if (bus_rvalid)
        q_rd <= q_rd + 1'b1;
      // owed responses of the aborted stream are dropped
      if (mis_now || err_seen)
        for (int k = 0; k < 8; k++)
          if (k < int'(outst) && !(bus_rvalid && k == 0))
            q_disc[q_rd + 3'(k)] <= 1'b1;
      if (grant)
      begin
        q_wr         <= q_wr + 1'b1;
        q_disc[q_wr] <= 1'b0;
        q_load[q_wr] <= !mem_we;
        q_exp[q_wr]  <= load_value(ref_mem[mem_adr[7:2]], mem_adr, mem_size);
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_rsp: assert property (@(posedge clk) disable iff (!rst_n) bus_rvalid |->
    mem_ack == (head_deliver && !bus_err) && mem_err == (head_deliver && bus_err))
    else report_fail("response ack/err does not match discard state");
  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !bus_rvalid |-> !mem_ack && !mem_err)
    else report_fail("ack or err without bus response");
  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ack && q_load[q_rd] |-> mem_q == q_exp[q_rd])
    else report_fail("load data");
  a_bus: assert property (@(posedge clk) disable iff (!rst_n) bus_req |->
    bus_adr == {mem_adr[31:2], 2'b00} && bus_be == exp_be(mem_adr, mem_size))
    else report_fail("bus address or byte enables");
  // store data must sit on every enabled lane
  a_wdata: assert property (@(posedge clk) disable iff (!rst_n) bus_req |->
    bus_we == mem_we && (!mem_we || store_merge(bus_d, mem_adr, mem_size, mem_d) == bus_d))
    else report_fail("bus write enable or store data");
  a_prot: assert property (@(posedge clk) disable iff (!rst_n) bus_req |->
    bus_prot == ((st_prv == PRV_U) ? 3'b011 : 3'b101))
    else report_fail("bus protection");
  a_mis: assert property (@(posedge clk) disable iff (!rst_n) mem_misaligned == mis_d)
    else report_fail("misaligned pulse");
  a_mis_noreq: assert property (@(posedge clk) disable iff (!rst_n) mis_now |-> !bus_req)
    else report_fail("bus request for a misaligned access");
  a_once: assert property (@(posedge clk) disable iff (!rst_n)
    grant |-> pending || (mem_req && !mis_now))
    else report_fail("grant without an open request");
  a_depth: assert property (@(posedge clk) disable iff (!rst_n) outst <= 3'd2)
    else report_fail("more than DEPTH transfers outstanding");

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial
  begin
    mem_req  = 1'b0;
    mem_adr  = '0;
    mem_size = SIZE_BYTE;
    mem_we   = 1'b0;
    mem_d    = '0;
    st_prv   = PRV_M;
    rst_n    = 1'b0;
    rnd      = 32'hcfcc_cfab;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NREQ; n++)
    begin
      @(negedge clk);
      rnd = lcg(rnd);
      case (rnd[31:29])
        3'd0, 3'd1:      mem_size = SIZE_BYTE;
        3'd2, 3'd3:      mem_size = SIZE_HWORD;
        3'd4, 3'd5, 3'd6: mem_size = SIZE_WORD;
        default:         mem_size = SIZE_DWORD;
      endcase
      mem_adr = {24'h0, rnd[27:20]};
      // mostly aligned, some misaligned on purpose
      if (rnd[19:17] != 3'd0)
      begin
        if (mem_size == SIZE_HWORD)
          mem_adr[0] = 1'b0;
        if (mem_size == SIZE_WORD)
          mem_adr[1:0] = 2'b00;
      end
      mem_we  = rnd[16];
      st_prv  = rnd[15] ? PRV_U : PRV_M;
      rnd     = lcg(rnd);
      mem_d   = rnd;
      mem_req = 1'b1;
      @(negedge clk);
      mem_req = 1'b0;
      while (pending)
        @(negedge clk);
      if (rnd[30])
        @(negedge clk);
    end
    while (outst != 0)
      @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (NREQ * 20) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", NREQ * 20);
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* sources.f */
src/dmem_pkg.sv
src/dmem_lane_fmt.sv
src/dmem_nodcache_core.sv
src/dmem_biu.sv
src/dmem_top.sv
dv/tb_bus_responder.sv
dv/tb_dmem_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_dmem_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST PASSED"; then
  exit 0
fi
exit 1
